//--- source/lc4_isa_pkg.sv
package lc4_isa_pkg;

   localparam int WORD_W    = 16; // data and address width
   localparam int REG_SEL_W = 3;  // r0..r7
   localparam int NZP_W     = 3;

   // opcodes in bits 15:12, all-zero word is a nop
   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_CONST = 4'b1001;

   // sub-operation in bits 5:3, bit 5 set means imm5 form
   localparam logic [2:0] ARITH_ADD = 3'b000;
   localparam logic [2:0] ARITH_SUB = 3'b010;
   localparam logic [2:0] LOGIC_AND = 3'b000;
   localparam logic [2:0] LOGIC_NOT = 3'b001;
   localparam logic [2:0] LOGIC_OR  = 3'b010;
   localparam logic [2:0] LOGIC_XOR = 3'b011;

   // one-hot condition codes
   localparam logic [NZP_W-1:0] NZP_NEG  = 3'b100;
   localparam logic [NZP_W-1:0] NZP_ZERO = 3'b010;
   localparam logic [NZP_W-1:0] NZP_POS  = 3'b001;

   typedef struct packed {
      logic [3:0]           opcode;
      logic [REG_SEL_W-1:0] rd;
      logic [REG_SEL_W-1:0] rs;
      logic [2:0]           sub;  // alu sub-op
      logic [REG_SEL_W-1:0] rt;
   } insn_reg_t;

   typedef struct packed {
      logic [3:0]           opcode;
      logic [REG_SEL_W-1:0] rd;
      logic [REG_SEL_W-1:0] rs;
      logic                 imm_flag; // same bit as sub[2]
      logic [4:0]           imm5;
   } insn_imm_t;

   typedef struct packed {
      logic [3:0]           opcode;
      logic [REG_SEL_W-1:0] rd;
      logic [8:0]           imm9; // signed constant
   } insn_cst_t;

   // one word, three ways to read it
   typedef union packed {
      insn_reg_t r;
      insn_imm_t i;
      insn_cst_t c;
   } lc4_insn_u;

endpackage

//--- source/lc4_pipe_pkg.sv
package lc4_pipe_pkg;

   // why a commit slot is empty
   typedef enum logic [1:0] {
      STALL_NONE  = 2'd0, // real insn
      STALL_SPLIT = 2'd1, // slot b dropped by a pair split
      STALL_RESET = 2'd2  // bubble left over from reset
   } stall_e;

   typedef struct packed {
      logic [lc4_isa_pkg::REG_SEL_W-1:0] rs_sel;
      logic                              rs_re;
      logic [lc4_isa_pkg::REG_SEL_W-1:0] rt_sel;
      logic                              rt_re;
      logic [lc4_isa_pkg::REG_SEL_W-1:0] rd_sel;
      logic                              rf_we;
      logic                              nzp_we;
   } ctrl_t;

   // one slot leaving decode
   typedef struct packed {
      stall_e                           stall;
      logic [lc4_isa_pkg::WORD_W-1:0]   pc;
      lc4_isa_pkg::lc4_insn_u           insn;
      ctrl_t                            ctrl;
   } issue_t;

   // one regfile write port, 20 bits
   typedef struct packed {
      logic                              we;
      logic [lc4_isa_pkg::REG_SEL_W-1:0] sel;
      logic [lc4_isa_pkg::WORD_W-1:0]    data;
   } wr_port_t;

   // what W reports per pipe
   typedef struct packed {
      stall_e                            stall;
      logic [lc4_isa_pkg::WORD_W-1:0]    pc;
      logic [lc4_isa_pkg::WORD_W-1:0]    insn;
      logic                              rf_we;
      logic [lc4_isa_pkg::REG_SEL_W-1:0] wsel;
      logic [lc4_isa_pkg::WORD_W-1:0]    wdata;
      logic                              nzp_we;
      logic [lc4_isa_pkg::NZP_W-1:0]     nzp;
   } commit_t;

endpackage

//--- source/lc4_decoder.sv
`timescale 1ns/10ps

module lc4_decoder (
   input  lc4_isa_pkg::lc4_insn_u i_insn,
   output lc4_pipe_pkg::ctrl_t    o_ctrl
);

   always_comb begin
      o_ctrl = '0; // nop and unknown opcodes enable nothing
      case (i_insn.r.opcode)
         lc4_isa_pkg::OP_ARITH: begin
            o_ctrl.rs_sel = i_insn.r.rs;
            o_ctrl.rs_re  = 1'b1;
            o_ctrl.rt_sel = i_insn.r.rt;
            o_ctrl.rt_re  = !i_insn.i.imm_flag; // imm5 form has no rt
            o_ctrl.rd_sel = i_insn.r.rd;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
         end
         lc4_isa_pkg::OP_LOGIC: begin
            o_ctrl.rs_sel = i_insn.r.rs;
            o_ctrl.rs_re  = 1'b1;
            o_ctrl.rt_sel = i_insn.r.rt;
            // NOT and the imm form read rs only
            o_ctrl.rt_re  = !i_insn.i.imm_flag &&
                            (i_insn.r.sub != lc4_isa_pkg::LOGIC_NOT);
            o_ctrl.rd_sel = i_insn.r.rd;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
         end
         lc4_isa_pkg::OP_CONST: begin
            o_ctrl.rd_sel = i_insn.c.rd; // no source regs
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

//--- source/lc4_alu.sv
`timescale 1ns/10ps

module lc4_alu (
   input  lc4_isa_pkg::lc4_insn_u           i_insn,
   input  logic [lc4_isa_pkg::WORD_W-1:0]   i_rs_val,
   input  logic [lc4_isa_pkg::WORD_W-1:0]   i_rt_val,
   output logic [lc4_isa_pkg::WORD_W-1:0]   o_result
);

   logic [lc4_isa_pkg::WORD_W-1:0] imm5_sx, imm9_sx;

   assign imm5_sx = {{(lc4_isa_pkg::WORD_W-5){i_insn.i.imm5[4]}}, i_insn.i.imm5};
   assign imm9_sx = {{(lc4_isa_pkg::WORD_W-9){i_insn.c.imm9[8]}}, i_insn.c.imm9};

   always_comb begin
      o_result = '0;
      case (i_insn.r.opcode)
         lc4_isa_pkg::OP_ARITH: begin
            if (i_insn.i.imm_flag) o_result = i_rs_val + imm5_sx;
            else begin
               case (i_insn.r.sub)
                  lc4_isa_pkg::ARITH_ADD: o_result = i_rs_val + i_rt_val;
                  lc4_isa_pkg::ARITH_SUB: o_result = i_rs_val - i_rt_val;
                  default:                o_result = '0; // mul and div not built
               endcase
            end
         end
         lc4_isa_pkg::OP_LOGIC: begin
            if (i_insn.i.imm_flag) o_result = i_rs_val & imm5_sx;
            else begin
               case (i_insn.r.sub)
                  lc4_isa_pkg::LOGIC_AND: o_result = i_rs_val & i_rt_val;
                  lc4_isa_pkg::LOGIC_NOT: o_result = ~i_rs_val;
                  lc4_isa_pkg::LOGIC_OR:  o_result = i_rs_val | i_rt_val;
                  lc4_isa_pkg::LOGIC_XOR: o_result = i_rs_val ^ i_rt_val;
                  default:                o_result = '0;
               endcase
            end
         end
         lc4_isa_pkg::OP_CONST: o_result = imm9_sx;
         default: ;
      endcase
   end

endmodule

//--- source/lc4_fetch_split.sv
`timescale 1ns/10ps

module lc4_fetch_split #(
   parameter logic [lc4_isa_pkg::WORD_W-1:0] START_PC = 16'h8200
) (
   input  logic                                gwe,
   input  logic                                i_rst,
   input  lc4_isa_pkg::lc4_insn_u              i_insn_a,  // word at pc
   input  lc4_isa_pkg::lc4_insn_u              i_insn_b,  // word at pc+1
   output logic [lc4_isa_pkg::WORD_W-1:0]      o_pc,
   output logic [lc4_isa_pkg::REG_SEL_W-1:0]   o_rs_sel_a,
   output logic [lc4_isa_pkg::REG_SEL_W-1:0]   o_rt_sel_a,
   output logic [lc4_isa_pkg::REG_SEL_W-1:0]   o_rs_sel_b,
   output logic [lc4_isa_pkg::REG_SEL_W-1:0]   o_rt_sel_b,
   output lc4_pipe_pkg::issue_t                o_issue_a,
   output lc4_pipe_pkg::issue_t                o_issue_b
);

   typedef struct packed {
      lc4_pipe_pkg::stall_e             stall;
      logic [lc4_isa_pkg::WORD_W-1:0]   pc;
      lc4_isa_pkg::lc4_insn_u           insn;
   } d_slot_t;

   logic [lc4_isa_pkg::WORD_W-1:0] pc_q;
   d_slot_t                        d_a_q, d_b_q; // D pair, a is older
   lc4_pipe_pkg::ctrl_t            ctrl_a, ctrl_b;
   logic                           split;

   lc4_decoder dec_a (.i_insn(d_a_q.insn), .o_ctrl(ctrl_a));
   lc4_decoder dec_b (.i_insn(d_b_q.insn), .o_ctrl(ctrl_b));

   // b reads what a writes in the same pair
   assign split = ctrl_a.rf_we &&
                  ((ctrl_b.rs_re && ctrl_b.rs_sel == ctrl_a.rd_sel) ||
                   (ctrl_b.rt_re && ctrl_b.rt_sel == ctrl_a.rd_sel));

   assign o_pc       = pc_q;
   assign o_rs_sel_a = ctrl_a.rs_sel;
   assign o_rt_sel_a = ctrl_a.rt_sel;
   assign o_rs_sel_b = ctrl_b.rs_sel;
   assign o_rt_sel_b = ctrl_b.rt_sel;

   always_comb begin
      o_issue_a = '{stall: d_a_q.stall, pc: d_a_q.pc, insn: d_a_q.insn, ctrl: ctrl_a};
      if (split) begin
         o_issue_b       = '0; // empty slot, b goes around again
         o_issue_b.stall = lc4_pipe_pkg::STALL_SPLIT;
      end else begin
         o_issue_b = '{stall: d_b_q.stall, pc: d_b_q.pc, insn: d_b_q.insn, ctrl: ctrl_b};
      end
   end

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         pc_q        <= START_PC;
         d_a_q       <= '0;
         d_a_q.stall <= lc4_pipe_pkg::STALL_RESET;
         d_b_q       <= '0;
         d_b_q.stall <= lc4_pipe_pkg::STALL_RESET;
      end else if (split) begin
         // old b becomes the older slot, one new word behind it
         d_a_q <= d_b_q;
         d_b_q <= '{stall: lc4_pipe_pkg::STALL_NONE, pc: pc_q, insn: i_insn_a};
         pc_q  <= pc_q + 16'd1;
      end else begin
         d_a_q <= '{stall: lc4_pipe_pkg::STALL_NONE, pc: pc_q, insn: i_insn_a};
         d_b_q <= '{stall: lc4_pipe_pkg::STALL_NONE, pc: pc_q + 16'd1, insn: i_insn_b};
         pc_q  <= pc_q + 16'd2; // full pair
      end
   end

endmodule

//--- source/lc4_regfile_dual.sv
`timescale 1ns/10ps

module lc4_regfile_dual (
   input  logic                              gwe,
   input  logic                              i_rst,
   input  logic [lc4_isa_pkg::REG_SEL_W-1:0] i_rs_sel_a,
   input  logic [lc4_isa_pkg::REG_SEL_W-1:0] i_rt_sel_a,
   input  logic [lc4_isa_pkg::REG_SEL_W-1:0] i_rs_sel_b,
   input  logic [lc4_isa_pkg::REG_SEL_W-1:0] i_rt_sel_b,
   output logic [lc4_isa_pkg::WORD_W-1:0]    o_rs_val_a,
   output logic [lc4_isa_pkg::WORD_W-1:0]    o_rt_val_a,
   output logic [lc4_isa_pkg::WORD_W-1:0]    o_rs_val_b,
   output logic [lc4_isa_pkg::WORD_W-1:0]    o_rt_val_b,
   input  lc4_pipe_pkg::wr_port_t            i_wr_a,    // older write
   input  lc4_pipe_pkg::wr_port_t            i_wr_b     // younger write
);

   logic [lc4_isa_pkg::WORD_W-1:0] regs [8];

   // read with same-cycle write bypass, b checked last so it wins
   function automatic logic [lc4_isa_pkg::WORD_W-1:0] rd_port(
      input logic [lc4_isa_pkg::REG_SEL_W-1:0] sel);
      logic [lc4_isa_pkg::WORD_W-1:0] val;
      val = regs[sel];
      if (i_wr_a.we && i_wr_a.sel == sel) val = i_wr_a.data;
      if (i_wr_b.we && i_wr_b.sel == sel) val = i_wr_b.data;
      return val;
   endfunction

   always_comb begin
      o_rs_val_a = rd_port(i_rs_sel_a);
      o_rt_val_a = rd_port(i_rt_sel_a);
      o_rs_val_b = rd_port(i_rs_sel_b);
      o_rt_val_b = rd_port(i_rt_sel_b);
   end

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int r = 0; r < 8; r++) regs[r] <= '0;
      end else begin
         if (i_wr_a.we) regs[i_wr_a.sel] <= i_wr_a.data;
         if (i_wr_b.we) regs[i_wr_b.sel] <= i_wr_b.data; // later nba, program order
      end
   end

endmodule

//--- source/lc4_execute.sv
`timescale 1ns/10ps

module lc4_execute (
   input  logic                            gwe,
   input  logic                            i_rst,
   input  lc4_pipe_pkg::issue_t            i_issue_a,
   input  lc4_pipe_pkg::issue_t            i_issue_b,
   input  logic [lc4_isa_pkg::WORD_W-1:0]  i_rs_val_a,
   input  logic [lc4_isa_pkg::WORD_W-1:0]  i_rt_val_a,
   input  logic [lc4_isa_pkg::WORD_W-1:0]  i_rs_val_b,
   input  logic [lc4_isa_pkg::WORD_W-1:0]  i_rt_val_b,
   output lc4_pipe_pkg::wr_port_t          o_wr_a,
   output lc4_pipe_pkg::wr_port_t          o_wr_b,
   output lc4_pipe_pkg::commit_t           o_commit_a,
   output lc4_pipe_pkg::commit_t           o_commit_b
);

   typedef struct packed {
      lc4_pipe_pkg::issue_t            iss;
      logic [lc4_isa_pkg::WORD_W-1:0]  rs_val; // regfile value from D
      logic [lc4_isa_pkg::WORD_W-1:0]  rt_val;
   } x_slot_t;

   x_slot_t                        x_a_q, x_b_q;
   lc4_pipe_pkg::commit_t          w_a_q, w_b_q;
   logic [lc4_isa_pkg::WORD_W-1:0] op_rs_a, op_rt_a, op_rs_b, op_rt_b;
   logic [lc4_isa_pkg::WORD_W-1:0] res_a, res_b;

   // W -> X bypass, W slot b is youngest so it is checked last
   function automatic logic [lc4_isa_pkg::WORD_W-1:0] fwd(
      input logic [lc4_isa_pkg::REG_SEL_W-1:0] sel,
      input logic [lc4_isa_pkg::WORD_W-1:0]    val);
      logic [lc4_isa_pkg::WORD_W-1:0] v;
      v = val;
      if (w_a_q.rf_we && w_a_q.wsel == sel) v = w_a_q.wdata;
      if (w_b_q.rf_we && w_b_q.wsel == sel) v = w_b_q.wdata;
      return v;
   endfunction

   function automatic lc4_pipe_pkg::commit_t mk_commit(
      input x_slot_t                        x,
      input logic [lc4_isa_pkg::WORD_W-1:0] res);
      lc4_pipe_pkg::commit_t c;
      c.stall  = x.iss.stall;
      c.pc     = x.iss.pc;
      c.insn   = x.iss.insn;
      c.rf_we  = x.iss.ctrl.rf_we;
      c.wsel   = x.iss.ctrl.rd_sel;
      c.wdata  = res;
      c.nzp_we = x.iss.ctrl.nzp_we;
      if (res[lc4_isa_pkg::WORD_W-1]) c.nzp = lc4_isa_pkg::NZP_NEG; // sign bit
      else if (res != '0)             c.nzp = lc4_isa_pkg::NZP_POS;
      else                            c.nzp = lc4_isa_pkg::NZP_ZERO;
      return c;
   endfunction

   always_comb begin
      op_rs_a = fwd(x_a_q.iss.ctrl.rs_sel, x_a_q.rs_val);
      op_rt_a = fwd(x_a_q.iss.ctrl.rt_sel, x_a_q.rt_val);
      op_rs_b = fwd(x_b_q.iss.ctrl.rs_sel, x_b_q.rs_val);
      op_rt_b = fwd(x_b_q.iss.ctrl.rt_sel, x_b_q.rt_val);
   end

   lc4_alu alu_a (.i_insn(x_a_q.iss.insn), .i_rs_val(op_rs_a), .i_rt_val(op_rt_a),
                  .o_result(res_a));
   lc4_alu alu_b (.i_insn(x_b_q.iss.insn), .i_rs_val(op_rs_b), .i_rt_val(op_rt_b),
                  .o_result(res_b));

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         x_a_q           <= '0;
         x_a_q.iss.stall <= lc4_pipe_pkg::STALL_RESET;
         x_b_q           <= '0;
         x_b_q.iss.stall <= lc4_pipe_pkg::STALL_RESET;
         w_a_q           <= '0; // we bits low while bubbles drain
         w_a_q.stall     <= lc4_pipe_pkg::STALL_RESET;
         w_b_q           <= '0;
         w_b_q.stall     <= lc4_pipe_pkg::STALL_RESET;
      end else begin
         x_a_q <= '{iss: i_issue_a, rs_val: i_rs_val_a, rt_val: i_rt_val_a};
         x_b_q <= '{iss: i_issue_b, rs_val: i_rs_val_b, rt_val: i_rt_val_b};
         w_a_q <= mk_commit(x_a_q, res_a);
         w_b_q <= mk_commit(x_b_q, res_b);
      end
   end

   assign o_wr_a     = '{we: w_a_q.rf_we, sel: w_a_q.wsel, data: w_a_q.wdata};
   assign o_wr_b     = '{we: w_b_q.rf_we, sel: w_b_q.wsel, data: w_b_q.wdata};
   assign o_commit_a = w_a_q;
   assign o_commit_b = w_b_q;

endmodule

//--- source/lc4_superscalar.sv
`timescale 1ns/10ps

module lc4_superscalar #(
   parameter logic [lc4_isa_pkg::WORD_W-1:0] START_PC = 16'h8200
) (
   input  logic                            gwe,
   input  logic                            i_rst,
   output logic [lc4_isa_pkg::WORD_W-1:0]  o_pc,
   input  lc4_isa_pkg::lc4_insn_u          i_insn_a,
   input  lc4_isa_pkg::lc4_insn_u          i_insn_b,
   output lc4_pipe_pkg::commit_t           o_commit_a,
   output lc4_pipe_pkg::commit_t           o_commit_b
);

   logic [lc4_isa_pkg::REG_SEL_W-1:0] rs_sel_a, rt_sel_a, rs_sel_b, rt_sel_b; // from D
   logic [lc4_isa_pkg::WORD_W-1:0]    rs_val_a, rt_val_a, rs_val_b, rt_val_b;
   lc4_pipe_pkg::issue_t              issue_a, issue_b;
   lc4_pipe_pkg::wr_port_t            wr_a, wr_b; // from W

   lc4_fetch_split #(.START_PC(START_PC)) u_fetch (
      .gwe(gwe), .i_rst(i_rst),
      .i_insn_a(i_insn_a), .i_insn_b(i_insn_b), .o_pc(o_pc),
      .o_rs_sel_a(rs_sel_a), .o_rt_sel_a(rt_sel_a),
      .o_rs_sel_b(rs_sel_b), .o_rt_sel_b(rt_sel_b),
      .o_issue_a(issue_a), .o_issue_b(issue_b)
   );

   lc4_regfile_dual u_regfile (
      .gwe(gwe), .i_rst(i_rst),
      .i_rs_sel_a(rs_sel_a), .i_rt_sel_a(rt_sel_a),
      .i_rs_sel_b(rs_sel_b), .i_rt_sel_b(rt_sel_b),
      .o_rs_val_a(rs_val_a), .o_rt_val_a(rt_val_a),
      .o_rs_val_b(rs_val_b), .o_rt_val_b(rt_val_b),
      .i_wr_a(wr_a), .i_wr_b(wr_b)
   );

   lc4_execute u_execute (
      .gwe(gwe), .i_rst(i_rst),
      .i_issue_a(issue_a), .i_issue_b(issue_b),
      .i_rs_val_a(rs_val_a), .i_rt_val_a(rt_val_a),
      .i_rs_val_b(rs_val_b), .i_rt_val_b(rt_val_b),
      .o_wr_a(wr_a), .o_wr_b(wr_b),
      .o_commit_a(o_commit_a), .o_commit_b(o_commit_b)
   );

endmodule

//--- tb/lc4_superscalar_chk.sv
`timescale 1ns/10ps

module lc4_superscalar_chk (
   input logic                  gwe,
   input logic                  i_rst,
   input lc4_pipe_pkg::commit_t i_commit_a, // W slot a
   input lc4_pipe_pkg::commit_t i_commit_b  // W slot b
);

   int fail_cnt = 0; // read by the testbench at the end

   // splits only ever empty the younger slot
   a_no_split_a: assert property (@(posedge gwe) disable iff (i_rst)
      i_commit_a.stall != lc4_pipe_pkg::STALL_SPLIT)
      else begin
         $error("W slot a holds a split bubble");
         fail_cnt++;
      end

   // bubbles write nothing
   a_bubble_quiet_a: assert property (@(posedge gwe) disable iff (i_rst)
      i_commit_a.stall != lc4_pipe_pkg::STALL_NONE |-> !i_commit_a.rf_we && !i_commit_a.nzp_we)
      else begin
         $error("bubble in W slot a has a write enable set");
         fail_cnt++;
      end

   a_bubble_quiet_b: assert property (@(posedge gwe) disable iff (i_rst)
      i_commit_b.stall != lc4_pipe_pkg::STALL_NONE |-> !i_commit_b.rf_we && !i_commit_b.nzp_we)
      else begin
         $error("bubble in W slot b has a write enable set");
         fail_cnt++;
      end

   // exactly one of n, z, p
   a_nzp_onehot_a: assert property (@(posedge gwe) disable iff (i_rst)
      i_commit_a.nzp_we |-> $onehot(i_commit_a.nzp))
      else begin
         $error("nzp bits of W slot a not one-hot");
         fail_cnt++;
      end

   a_nzp_onehot_b: assert property (@(posedge gwe) disable iff (i_rst)
      i_commit_b.nzp_we |-> $onehot(i_commit_b.nzp))
      else begin
         $error("nzp bits of W slot b not one-hot");
         fail_cnt++;
      end

endmodule

bind lc4_execute lc4_superscalar_chk u_chk (
   .gwe(gwe), .i_rst(i_rst),
   .i_commit_a(o_commit_a), .i_commit_b(o_commit_b)
);

//--- tb/lc4_superscalar_tb.sv
`timescale 1ns/10ps

module lc4_superscalar_tb;

   localparam logic [lc4_isa_pkg::WORD_W-1:0] START_PC = 16'h8200;
   localparam int MAX_PROG   = 32; // words per test program
   localparam int RST_CYCLES = 4;

   logic                            gwe = 1'b0;
   logic                            i_rst = 1'b1; // core held from time 0
   logic [lc4_isa_pkg::WORD_W-1:0]  o_pc;
   lc4_isa_pkg::lc4_insn_u          i_insn_a;
   lc4_isa_pkg::lc4_insn_u          i_insn_b;
   lc4_pipe_pkg::commit_t           o_commit_a;
   lc4_pipe_pkg::commit_t           o_commit_b;

   logic [15:0] imem [MAX_PROG];     // program of the current test
   logic [15:0] exp_pc [MAX_PROG];   // expected commits in program order
   logic [2:0]  exp_wsel [MAX_PROG];
   logic [15:0] exp_data [MAX_PROG];
   logic [15:0] off_a;
   logic [15:0] off_b;
   int          prog_len = 0;
   int          cyc = 0;
   int          test_t0 = 0;
   int          cyc_limit = 0;
   logic        armed = 1'b0;        // watchdog starts with the first test
   int          got_cnt = 0;
   int          split_cnt = 0;
   int          test_err = 0;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_bad = 0;
   string       test_name = "";

   lc4_superscalar #(.START_PC(START_PC)) DUT (
      .gwe(gwe), .i_rst(i_rst), .o_pc(o_pc),
      .i_insn_a(i_insn_a), .i_insn_b(i_insn_b),
      .o_commit_a(o_commit_a), .o_commit_b(o_commit_b)
   );

   always #5 gwe = ~gwe; // 10 ns period

   always @(posedge gwe) cyc <= cyc + 1;

   // instruction memory read straight from the pc and nop outside the program
   always_comb begin
      off_a    = o_pc - START_PC;
      off_b    = o_pc - START_PC + 16'd1;
      i_insn_a = '0;
      i_insn_b = '0;
      if (!i_rst && off_a < prog_len) i_insn_a = imem[off_a];
      if (!i_rst && off_b < prog_len) i_insn_b = imem[off_b];
   end

   // commit record for trace entry idx with nzp from sign and zero of the data
   function automatic lc4_pipe_pkg::commit_t expect_commit(input int idx);
      lc4_pipe_pkg::commit_t c;
      logic [15:0]           off;
      off      = exp_pc[idx] - START_PC;
      c        = '0;
      c.stall  = lc4_pipe_pkg::STALL_NONE;
      c.pc     = exp_pc[idx];
      c.insn   = imem[off];
      c.rf_we  = 1'b1;
      c.wsel   = exp_wsel[idx];
      c.wdata  = exp_data[idx];
      c.nzp_we = 1'b1;
      if (exp_data[idx][15])           c.nzp = lc4_isa_pkg::NZP_NEG;
      else if (exp_data[idx] == 16'h0) c.nzp = lc4_isa_pkg::NZP_ZERO;
      else                             c.nzp = lc4_isa_pkg::NZP_POS;
      return c;
   endfunction

   task automatic compare_commit(input lc4_pipe_pkg::commit_t got,
                                 input lc4_pipe_pkg::commit_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: pc %h insn %h we %b%b wsel %0d data %h nzp %b", $time,
                  got.pc, got.insn, got.rf_we, got.nzp_we, got.wsel, got.wdata, got.nzp);
         $display("   expected pc %h insn %h we %b%b wsel %0d data %h nzp %b",
                  exp.pc, exp.insn, exp.rf_we, exp.nzp_we, exp.wsel, exp.wdata, exp.nzp);
         test_err++;
      end
   endtask

   task automatic compare_pc(input logic [lc4_isa_pkg::WORD_W-1:0] got,
                             input logic [lc4_isa_pkg::WORD_W-1:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: pc %h after reset, expected %h", $time, got, exp);
         test_err++;
      end
   endtask

   task automatic compare_splits(input int got, input int exp);
      if (got != exp) begin
         $display("Mismatch at %0t: %0d split slots, expected %0d", $time, got, exp);
         test_err++;
      end
   endtask

   // program commits of one W slot checked in order
   task automatic take_slot(input lc4_pipe_pkg::commit_t c);
      logic [15:0] off;
      off = c.pc - START_PC;
      if (c.stall == lc4_pipe_pkg::STALL_SPLIT) split_cnt++;
      else if (c.stall == lc4_pipe_pkg::STALL_NONE && off < prog_len && got_cnt < prog_len) begin
         compare_commit(c, expect_commit(got_cnt));
         got_cnt++;
      end
   endtask

   task automatic reset_core();
      @(posedge gwe);
      i_rst <= 1'b1;
      repeat (RST_CYCLES) @(posedge gwe);
      i_rst <= 1'b0;
   endtask

   task automatic run_test(input int nsplit);
      test_t0   = cyc;
      cyc_limit = 2 * prog_len + 20 + RST_CYCLES + 1; // reset counts too
      armed     = 1'b1;
      got_cnt   = 0;
      split_cnt = 0;
      test_err  = 0;
      reset_core();
      @(negedge gwe);              // first fetch after reset
      compare_pc(o_pc, START_PC);
      while (got_cnt < prog_len) begin
         take_slot(o_commit_a);    // older slot first
         take_slot(o_commit_b);
         if (got_cnt < prog_len) @(negedge gwe); // W outputs settled
      end
      compare_splits(split_cnt, nsplit);
      tests_run++;
      if (test_err != 0) tests_bad++;
      errors += test_err;
      $display("test %0s: %0s, %0d commits, %0d splits", test_name,
               (test_err == 0) ? "ok" : "FAIL", got_cnt, split_cnt);
   endtask

   initial begin : main
      int          fd;
      int          c;
      int          rc;
      int          n;
      int          nsplit;
      int          i;
      string       kw;
      fd = $fopen("tb/lc4_trace.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the trace file tb/lc4_trace.txt");
         errors++;
      end else begin
         while ($fscanf(fd, "%s", kw) == 1) begin
            if (kw == "#") begin
               c = $fgetc(fd);
               while (c != 10 && c != -1) c = $fgetc(fd); // skip comment line
            end else if (kw == "test") begin
               rc = $fscanf(fd, "%s %d %d", test_name, n, nsplit);
               if (rc != 3 || n < 1 || n > MAX_PROG) begin
                  $display("Bad test header in the trace file after %0s", test_name);
                  errors++;
                  break;
               end
               for (i = 0; i < MAX_PROG; i++) imem[i] = '0;
               for (i = 0; i < n; i++) rc = $fscanf(fd, "%h", imem[i]);
               for (i = 0; i < n; i++)
                  rc = $fscanf(fd, "%h %h %h", exp_pc[i], exp_wsel[i], exp_data[i]);
               prog_len = n;
               run_test(nsplit);
            end else begin
               $display("Unknown keyword %0s in the trace file", kw);
               errors++;
            end
         end
         $fclose(fd);
      end
      if (tests_run == 0) begin
         $display("No test was run from the trace file");
         errors++;
      end
      if (DUT.u_execute.u_chk.fail_cnt != 0) begin
         $display("Execute checker reported %0d assertion failures",
                  DUT.u_execute.u_chk.fail_cnt);
         errors += DUT.u_execute.u_chk.fail_cnt;
      end
      $display("tests %0d, failing %0d, errors %0d", tests_run, tests_bad, errors);
      if (errors == 0) $display("Regression passed");
      else $display("Regression failed");
      $finish;
   end

   // per test cycle budget from the program length
   initial begin : watchdog
      wait (armed);
      while (cyc - test_t0 <= cyc_limit) @(negedge gwe);
      $display("Timeout: test %0s did not commit its program within %0d cycles",
               test_name, cyc_limit);
      $display("Regression failed");
      $finish;
   end

endmodule

//--- build.f
source/lc4_isa_pkg.sv
source/lc4_pipe_pkg.sv
source/lc4_decoder.sv
source/lc4_alu.sv
source/lc4_fetch_split.sv
source/lc4_regfile_dual.sv
source/lc4_execute.sv
source/lc4_superscalar.sv
tb/lc4_superscalar_chk.sv
tb/lc4_superscalar_tb.sv

//--- tb/lc4_trace.txt
# test <name> <program length> <expected split slots>, then the program words in hex,
# then one expected commit per instruction as pc, wsel and data in hex
# independent pairs, every alu operation once
test indep 10 0
9205 95fd 1642 1852 5a42 5c52 5e5a 5048 12fc 552c
8200 1 0005  8201 2 fffd  8202 3 0002  8203 4 0008  8204 5 0005
8205 6 fffd  8206 7 fff8  8207 0 fffa  8208 1 fffe  8209 2 0008
# b reads the rd of a twice, two split slots
test split 5 2
9207 1441 9601 1883 5b08
8200 1 0007  8201 2 000e  8202 3 0001  8203 4 000f  8204 5 fff0
# every pair reads the results of the pair before
test chain 10 0
9203 9404 1642 1891 12c4 14d4 565a 5842 1b13 1ce5
8200 1 0003  8201 2 0004  8202 3 0007  8203 4 0001  8204 1 0008
8205 2 0006  8206 3 000e  8207 4 0000  8208 5 fff2  8209 6 0013
# both slots of a pair write one register, later reads see slot b
test samereg 10 0
920a 9214 1460 9700 9801 9802 1a44 5c53 1f11 1104
8200 1 000a  8201 1 0014  8202 2 0014  8203 3 ff00  8204 4 0001
8205 4 0002  8206 5 0016  8207 6 ff14  8208 7 ffee  8209 0 0004
